//--- logic/branch_pkg.sv
// branch_pkg: shared widths, bus and resolve structs, register map and bus states
package branch_pkg;

    typedef logic [31:0] pc_t;         // fetch and execute program counter
    typedef logic [1:0]  pht_cnt_t;    // saturating counter, msb set means predict taken
    typedef logic [31:0] stat_cnt_t;   // one statistics counter, one bus word wide
    typedef logic [31:0] wb_data_t;    // wishbone data word
    typedef logic [3:0]  wb_adr_t;     // wishbone word address

    localparam pht_cnt_t PHT_RESET = 2'b01;  // weakly not taken after reset

    typedef struct packed {
        logic valid;      // a conditional branch resolved this cycle
        pc_t  pc;         // pc of the resolved branch
        logic predicted;  // direction that fetch was told
        logic taken;      // direction the branch really went
    } resolve_t;

    // field order is also the register map order, address 0 first
    typedef struct packed {
        stat_cnt_t prediction_count;
        stat_cnt_t misprediction_count;
        stat_cnt_t correct_count;
        stat_cnt_t pred_taken_count;
        stat_cnt_t pred_not_taken_count;
        stat_cnt_t taken_incorrect_count;
        stat_cnt_t not_taken_incorrect_count;
    } stats_t;

    typedef struct packed {
        logic     cyc;  // bus cycle in progress
        logic     stb;  // strobe, valid transfer
        logic     we;   // write enable
        wb_adr_t  adr;  // word address
        wb_data_t dat;  // write data
    } wb_req_t;

    typedef struct packed {
        logic     ack;  // one cycle acknowledge
        wb_data_t dat;  // read data, valid with ack
    } wb_rsp_t;

    typedef enum logic [3:0] {
        PRED_CNT_REG        = 4'd0,
        MISPRED_CNT_REG     = 4'd1,
        CORRECT_CNT_REG     = 4'd2,
        PRED_TAKEN_REG      = 4'd3,
        PRED_NOT_TAKEN_REG  = 4'd4,
        TAKEN_WRONG_REG     = 4'd5,
        NOT_TAKEN_WRONG_REG = 4'd6,
        CTRL_REG            = 4'd7   // any write clears all counters
    } stat_reg_e;

    typedef enum logic {
        BUS_IDLE = 1'b0,  // waiting for cyc and stb
        BUS_ACK  = 1'b1   // acknowledging the sampled request
    } bus_state_e;

endpackage

//--- logic/bimodal_predictor.sv
// bimodal_predictor: pattern history table of 2-bit counters, same-cycle lookup, learns on resolve
`timescale 1ns/1ps

module bimodal_predictor import branch_pkg::*; #(
    parameter int IDX_W = 6                  // log2 of the number of table entries
) (
    input  logic     CLK,
    input  logic     nRST,
    input  pc_t      lookup_pc,              // pc presented by fetch
    output logic     predict_taken,          // direction for lookup_pc, combinational
    input  resolve_t resolve                 // resolved branch from execute
);

    localparam int DEPTH = 2 ** IDX_W;       // entries in the table

    typedef logic [IDX_W-1:0] pht_idx_t;     // table index taken from the pc

    // the index slice starts at bit 2 and must fit inside a pc
    if (IDX_W < 1 || IDX_W > 30) begin : g_idx_w_check
        $error("bimodal_predictor: IDX_W must be between 1 and 30");
    end

    pht_cnt_t pht [DEPTH];                   // one counter per entry
    pht_idx_t lookup_idx;                    // entry read for fetch
    pht_idx_t update_idx;                    // entry written on resolve
    pht_cnt_t update_cur;                    // counter before the update
    pht_cnt_t update_nxt;                    // counter after the saturating step

    // word aligned instructions, so the two low pc bits carry no information
    assign lookup_idx = lookup_pc[IDX_W+1:2];
    assign update_idx = resolve.pc[IDX_W+1:2];

    // lookup reads the old value even when a resolve hits the same entry this cycle
    assign predict_taken = pht[lookup_idx][1];  // upper counter bit is the prediction

    assign update_cur = pht[update_idx];

    always_comb begin
        update_nxt = update_cur;                // saturated counters stay put
        if (resolve.taken) begin
            if (update_cur != 2'b11) begin
                update_nxt = update_cur + 2'b01;  // one step towards strongly taken
            end
        end else begin
            if (update_cur != 2'b00) begin
                update_nxt = update_cur - 2'b01;  // one step towards strongly not taken
            end
        end
    end

    // the table is part of the reset state, all entries start weakly not taken
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < DEPTH; i++) begin
                pht[i] <= PHT_RESET;
            end
        end else if (resolve.valid) begin
            pht[update_idx] <= update_nxt;      // learn from the resolved outcome
        end
    end

    // the prediction depends on the fetch pc and on every entry the resolve port has written
    a_predict_known: assert property (
        @(posedge CLK) disable iff (!nRST)
        !$isunknown(lookup_pc) |-> !$isunknown(predict_taken)
    ) else $error("bimodal_predictor: predict_taken is unknown for a known pc");

    // a valid resolve must carry a known pc and outcome or the table gets corrupted
    a_resolve_known: assert property (
        @(posedge CLK) disable iff (!nRST)
        resolve.valid |-> !$isunknown({resolve.pc[IDX_W+1:2], resolve.taken})
    ) else $error("bimodal_predictor: valid resolve with unknown pc or outcome");

endmodule

//--- logic/branch_tracker.sv
// branch_tracker: seven prediction outcome counters with a synchronous clear from the bus
`timescale 1ns/1ps

module branch_tracker import branch_pkg::*; (
    input  logic     CLK,
    input  logic     nRST,
    input  resolve_t resolve,                 // resolved branch from execute
    input  logic     stats_clear,             // one cycle pulse from the bus slave
    output stats_t   stats                    // all counters, read by the bus slave
);

    localparam stat_cnt_t CNT_ONE = 32'd1;   // increment step

    logic correct;                            // prediction matched the outcome
    logic wrong_taken;                        // predicted taken, went not taken
    logic wrong_not_taken;                    // predicted not taken, went taken

    // the four cases of predicted against taken
    assign correct         = (resolve.predicted == resolve.taken);
    assign wrong_taken     = resolve.predicted && !resolve.taken;
    assign wrong_not_taken = !resolve.predicted && resolve.taken;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            stats <= '0;                                  // all counters start at zero
        end else if (stats_clear) begin
            stats <= '0;                                  // clear wins over a resolve in the same cycle
        end else if (resolve.valid) begin
            stats.prediction_count <= stats.prediction_count + CNT_ONE;  // every resolved branch

            if (resolve.predicted) begin
                stats.pred_taken_count <= stats.pred_taken_count + CNT_ONE;
            end else begin
                stats.pred_not_taken_count <= stats.pred_not_taken_count + CNT_ONE;
            end

            if (correct) begin
                stats.correct_count <= stats.correct_count + CNT_ONE;
            end else begin
                stats.misprediction_count <= stats.misprediction_count + CNT_ONE;
            end

            if (wrong_taken) begin
                stats.taken_incorrect_count <= stats.taken_incorrect_count + CNT_ONE;
            end

            if (wrong_not_taken) begin
                stats.not_taken_incorrect_count <= stats.not_taken_incorrect_count + CNT_ONE;
            end
        end
    end

    // Correct-taken and correct-not-taken follow from pred_taken minus taken_incorrect
    // and so on. Software works them out from the bus, so they get no counter here.

    // the sums wrap at 32 bits on both sides, so these also hold after overflow
    a_total_split_by_outcome: assert property (
        @(posedge CLK) disable iff (!nRST)
        stats.prediction_count == stat_cnt_t'(stats.correct_count + stats.misprediction_count)
    ) else $error("branch_tracker: total differs from correct plus mispredicted");

    a_total_split_by_direction: assert property (
        @(posedge CLK) disable iff (!nRST)
        stats.prediction_count ==
            stat_cnt_t'(stats.pred_taken_count + stats.pred_not_taken_count)
    ) else $error("branch_tracker: total differs from predicted taken plus not taken");

endmodule

//--- logic/stats_bus_fsm.sv
// stats_bus_fsm: wishbone classic slave that reads the statistics counters and issues the clear
`timescale 1ns/1ps

module stats_bus_fsm import branch_pkg::*; (
    input  logic    CLK,
    input  logic    nRST,
    input  wb_req_t wb_req,                   // request from the wishbone master
    output wb_rsp_t wb_rsp,                   // ack and read data back to the master
    input  stats_t  stats,                    // live counters from the tracker
    output logic    stats_clear               // one cycle clear pulse to the tracker
);

    bus_state_e state;                        // idle or acknowledging
    bus_state_e state_nxt;
    logic       req;                          // cyc and stb together form a request
    logic       clear_pend;                   // sampled request was a write to CTRL_REG
    stat_reg_e  reg_sel;                      // register addressed by the request
    wb_data_t   rd_mux;                       // read data chosen by the address
    wb_data_t   rd_data;                      // read data held for the ack cycle

    assign req     = wb_req.cyc && wb_req.stb;
    assign reg_sel = stat_reg_e'(wb_req.adr);

    // counters in register map order, ctrl and unmapped words read as zero
    always_comb begin
        case (reg_sel)
            PRED_CNT_REG:        rd_mux = stats.prediction_count;
            MISPRED_CNT_REG:     rd_mux = stats.misprediction_count;
            CORRECT_CNT_REG:     rd_mux = stats.correct_count;
            PRED_TAKEN_REG:      rd_mux = stats.pred_taken_count;
            PRED_NOT_TAKEN_REG:  rd_mux = stats.pred_not_taken_count;
            TAKEN_WRONG_REG:     rd_mux = stats.taken_incorrect_count;
            NOT_TAKEN_WRONG_REG: rd_mux = stats.not_taken_incorrect_count;
            default:             rd_mux = '0;
        endcase
    end

    always_comb begin
        state_nxt = state;
        case (state)
            BUS_IDLE: begin
                if (req) begin
                    state_nxt = BUS_ACK;      // answer on the following cycle
                end
            end
            BUS_ACK: begin
                state_nxt = BUS_IDLE;         // ack lasts exactly one cycle
            end
            default: begin
                state_nxt = BUS_IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state      <= BUS_IDLE;
            clear_pend <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == BUS_IDLE && req) begin
                clear_pend <= wb_req.we && (reg_sel == CTRL_REG);  // writes elsewhere are dropped
            end else begin
                clear_pend <= 1'b0;           // pulse ends with the ack
            end
        end
    end

    // read data only means something while ack is high
    always_ff @(posedge CLK) begin
        if (state == BUS_IDLE && req) begin
            rd_data <= wb_req.we ? '0 : rd_mux;  // sampled at the same edge as the request
        end
    end

    assign wb_rsp.ack = (state == BUS_ACK);
    assign wb_rsp.dat = rd_data;
    assign stats_clear = clear_pend;          // already only high in the ack cycle

    // the master holds cyc and stb until it sees ack, so an ack never stands alone
    a_ack_inside_request: assert property (
        @(posedge CLK) disable iff (!nRST)
        wb_rsp.ack |-> (wb_req.cyc && wb_req.stb)
    ) else $error("stats_bus_fsm: ack without cyc and stb");

endmodule

//--- logic/branch_unit_top.sv
// branch_unit_top: bimodal branch predictor with outcome statistics readable over wishbone
`timescale 1ns/1ps

module branch_unit_top import branch_pkg::*; #(
    parameter int IDX_W = 6                   // log2 of the pattern history table depth
) (
    input  logic     CLK,
    input  logic     nRST,
    input  pc_t      lookup_pc,               // fetch pc
    output logic     predict_taken,           // same cycle prediction for lookup_pc
    input  resolve_t resolve,                 // resolved conditional branch from execute
    input  wb_req_t  wb_req,                  // wishbone classic master request
    output wb_rsp_t  wb_rsp                   // wishbone slave response
);

    stats_t stats;                            // counters from the tracker to the bus slave
    logic   stats_clear;                      // clear pulse from the bus slave to the tracker

    // prediction and learning, the table index width is set here
    bimodal_predictor #(
        .IDX_W         (IDX_W)
    ) i_bimodal_predictor (
        .CLK           (CLK),
        .nRST          (nRST),
        .lookup_pc     (lookup_pc),
        .predict_taken (predict_taken),
        .resolve       (resolve)
    );

    // outcome counting sees the same resolve as the predictor
    branch_tracker i_branch_tracker (
        .CLK           (CLK),
        .nRST          (nRST),
        .resolve       (resolve),
        .stats_clear   (stats_clear),
        .stats         (stats)
    );

    // bus access to the counters
    stats_bus_fsm i_stats_bus_fsm (
        .CLK           (CLK),
        .nRST          (nRST),
        .wb_req        (wb_req),
        .wb_rsp        (wb_rsp),
        .stats         (stats),
        .stats_clear   (stats_clear)
    );

endmodule

//--- tb/branch_unit_checks.svh
// branch unit checks: wishbone classic master tasks and typed compare tasks for the testbench
`ifndef BRANCH_UNIT_CHECKS_SVH
`define BRANCH_UNIT_CHECKS_SVH

// single bit results such as predict_taken and ack
task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual === expected) begin
        pass_cnt++;
    end else begin
        err_cnt++;
        $display("error at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
    end
endtask

// statistics counters read over the bus
task automatic check_stat(input string name, input stat_cnt_t actual, input stat_cnt_t expected);
    if (actual === expected) begin
        pass_cnt++;
    end else begin
        err_cnt++;
        $display("error at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
    end
endtask

// one classic cycle, request on a falling edge, held until ack, dropped after it
task automatic wb_access(input logic we, input wb_adr_t adr, input wb_data_t wdat,
                         output wb_data_t rdat);
    int wait_cnt;
    @(negedge CLK);
    pred_chk_en  = 1'b0;                      // no prediction compare during bus traffic
    resolve      = '0;
    wb_req.cyc   = 1'b1;
    wb_req.stb   = 1'b1;
    wb_req.we    = we;
    wb_req.adr   = adr;
    wb_req.dat   = wdat;
    rdat         = '0;
    @(posedge CLK);                           // the slave samples the request at this edge
    check_bit("wb_rsp.ack", wb_rsp.ack, 1'b0);  // nothing may be acknowledged yet
    @(posedge CLK);
    wait_cnt = 1;
    while (!wb_rsp.ack && wait_cnt < ACK_WAIT_MAX) begin
        @(posedge CLK);
        wait_cnt++;
    end
    if (!wb_rsp.ack) begin
        err_cnt++;
        $display("bus slave gave no ack for address %0d within %0d cycles", adr, wait_cnt);
    end else begin
        rdat = wb_rsp.dat;                    // read data is valid while ack is high
        if (wait_cnt != 1) begin
            err_cnt++;
            $display("bus slave acked address %0d after %0d cycles instead of 1", adr, wait_cnt);
        end
    end
    @(negedge CLK);
    wb_req = '0;                              // master drops stb the cycle after ack
    @(posedge CLK);
    check_bit("wb_rsp.ack", wb_rsp.ack, 1'b0);  // ack lasts one cycle only
endtask

task automatic wb_read(input wb_adr_t adr, output wb_data_t data);
    wb_access(1'b0, adr, '0, data);
endtask

task automatic wb_write(input wb_adr_t adr, input wb_data_t data);
    wb_data_t ignored_rd;                     // writes return no useful data
    wb_access(1'b1, adr, data, ignored_rd);
endtask

`endif

//--- tb/branch_unit_tb.sv
// branch_unit_tb: testbench for the bimodal branch predictor and its wishbone statistics block
`timescale 1ns/1ps

module branch_unit_tb import branch_pkg::*; ();

    localparam int unsigned SEED = 85710;
    localparam int MODEL_IDX_W       = 6;     // table index width given to the DUT and the model
    localparam int NUM_PCS           = 12;    // branch sites in the random stream
    localparam int NUM_RESET_LOOKUPS = 4;
    localparam int NUM_RANDOM        = 400;
    localparam int NUM_ALIAS         = 8;     // six trained branches and two lookups
    localparam int NUM_AFTER_CLEAR   = 24;
    localparam int NUM_BUS           = 46;    // all wishbone accesses of the run
    localparam int ACK_WAIT_MAX      = 8;
    localparam int CYCLE_LIMIT = 16 + 2 * (NUM_RESET_LOOKUPS + NUM_RANDOM + NUM_ALIAS
        + NUM_AFTER_CLEAR) + 4 * NUM_BUS + 200;

    logic        CLK;
    logic        nRST;
    pc_t         lookup_pc;
    logic        predict_taken;
    resolve_t    resolve;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;

    pht_cnt_t    model_pht [2**MODEL_IDX_W];  // reference copy of the pattern history table
    stats_t      model_st;                    // reference outcome counts
    pc_t         pc_list [NUM_PCS];
    int unsigned bias [NUM_PCS];              // percent chance that a site is taken
    logic        pred_chk_en;                 // compare predict_taken at the next rising edge
    logic        pred_exp;
    int          err_cnt;
    int          pass_cnt;
    int          cycle_cnt;

    `include "branch_unit_checks.svh"

    branch_unit_top #(
        .IDX_W         (MODEL_IDX_W)
    ) i_branch_unit_top (
        .CLK           (CLK),
        .nRST          (nRST),
        .lookup_pc     (lookup_pc),
        .predict_taken (predict_taken),
        .resolve       (resolve),
        .wb_req        (wb_req),
        .wb_rsp        (wb_rsp)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;                // 8 ns period
    end

    // the prediction is combinational, so it is stable at the edge after the falling edge drive
    always @(posedge CLK) begin : compare_prediction
        if (pred_chk_en) begin
            check_bit("predict_taken", predict_taken, pred_exp);
        end
    end

    // run length limit, from the cycles each branch and bus access needs
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge CLK);
            cycle_cnt++;
        end
        $display("timeout: run stopped after %0d cycles with tests still running", cycle_cnt);
        $display("*** FAILED ***");
        $finish;
    end

    // upper counter bit is the direction, index from pc bit 2 upwards
    function automatic logic model_predict(input pc_t pc);
        return model_pht[pc[MODEL_IDX_W+1:2]][1];
    endfunction

    // 2-bit saturating step, held at 0 and at 3
    function automatic pht_cnt_t saturate_step(input pht_cnt_t cnt, input logic taken);
        if (taken) begin
            return (cnt == 2'd3) ? cnt : cnt + 2'd1;
        end
        return (cnt == 2'd0) ? cnt : cnt - 2'd1;
    endfunction

    function automatic stats_t model_stats(input stats_t s, input logic predicted,
                                           input logic taken);
        stats_t n;
        n = s;
        n.prediction_count = n.prediction_count + 32'd1;
        if (predicted) begin
            n.pred_taken_count = n.pred_taken_count + 32'd1;
        end else begin
            n.pred_not_taken_count = n.pred_not_taken_count + 32'd1;
        end
        if (predicted == taken) begin
            n.correct_count = n.correct_count + 32'd1;
        end else begin
            n.misprediction_count = n.misprediction_count + 32'd1;
            if (predicted) begin
                n.taken_incorrect_count = n.taken_incorrect_count + 32'd1;
            end else begin
                n.not_taken_incorrect_count = n.not_taken_incorrect_count + 32'd1;
            end
        end
        return n;
    endfunction

    // register map, address 0 to 6 in counter order
    function automatic stat_cnt_t expected_reg(input stats_t s, input int adr);
        case (adr)
            0:       return s.prediction_count;
            1:       return s.misprediction_count;
            2:       return s.correct_count;
            3:       return s.pred_taken_count;
            4:       return s.pred_not_taken_count;
            5:       return s.taken_incorrect_count;
            6:       return s.not_taken_incorrect_count;
            default: return '0;
        endcase
    endfunction

    function automatic string reg_name(input int adr);
        case (adr)
            0:       return "prediction_count";
            1:       return "misprediction_count";
            2:       return "correct_count";
            3:       return "pred_taken_count";
            4:       return "pred_not_taken_count";
            5:       return "taken_incorrect_count";
            6:       return "not_taken_incorrect_count";
            default: return "unmapped register";
        endcase
    endfunction

    // one fetch cycle with no resolve, the prediction is compared at the rising edge
    task automatic lookup_cycle(input pc_t pc, input logic expected);
        @(negedge CLK);
        lookup_pc   = pc;
        resolve     = '0;
        pred_exp    = expected;
        pred_chk_en = 1'b1;
        @(posedge CLK);
    endtask

    // fetch cycle, then the resolve cycle with the same pc still looked up
    task automatic run_branch(input pc_t pc, input logic taken);
        logic pred;
        pred = model_predict(pc);
        lookup_cycle(pc, pred);
        @(negedge CLK);
        resolve.valid     = 1'b1;
        resolve.pc        = pc;
        resolve.predicted = pred;             // the direction fetch was given
        resolve.taken     = taken;
        @(posedge CLK);                       // same cycle lookup still sees the old counter
        model_pht[pc[MODEL_IDX_W+1:2]] = saturate_step(model_pht[pc[MODEL_IDX_W+1:2]], taken);
        model_st = model_stats(model_st, pred, taken);
    endtask

    task automatic run_random_branches(input int count);
        int   k;
        logic taken;
        for (int i = 0; i < count; i++) begin
            k     = int'($urandom_range(NUM_PCS - 1));
            taken = ($urandom_range(99) < bias[k]);  // per site bias
            run_branch(pc_list[k], taken);
        end
    endtask

    task automatic check_all_counters(input stats_t exp);
        wb_data_t data;
        for (int a = 0; a < 7; a++) begin
            wb_read(wb_adr_t'(a), data);
            check_stat(reg_name(a), data, expected_reg(exp, a));
        end
    endtask

    task automatic finish_test(input string name, input int errs_at_start);
        @(negedge CLK);                       // lets the last compare at the rising edge land
        resolve     = '0;                     // the last branch of a test is resolved only once
        pred_chk_en = 1'b0;
        if (err_cnt == errs_at_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, err_cnt - errs_at_start);
        end
    endtask

    initial begin
        int       errs;
        wb_data_t data;
        pc_t      alias_a;
        pc_t      alias_b;
        nRST        = 1'b0;
        lookup_pc   = '0;
        resolve     = '0;
        wb_req      = '0;
        pred_chk_en = 1'b0;
        pred_exp    = 1'b0;
        err_cnt     = 0;
        pass_cnt    = 0;
        model_st    = '0;
        for (int i = 0; i < 2**MODEL_IDX_W; i++) begin
            model_pht[i] = PHT_RESET;
        end
        void'($urandom(SEED));                // the one seed of the run
        for (int k = 0; k < NUM_PCS; k++) begin
            pc_list[k] = 32'h0000_4000 + 32'(k * 20);  // word aligned, distinct entries
            bias[k]    = $urandom_range(100);
        end
        repeat (16) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        errs = err_cnt;
        check_all_counters(model_st);
        for (int k = 0; k < NUM_RESET_LOOKUPS; k++) begin
            lookup_cycle(pc_list[k * 3], 1'b0);  // weakly not taken everywhere
        end
        finish_test("reset state", errs);

        errs = err_cnt;
        run_random_branches(NUM_RANDOM);
        finish_test("random branch stream", errs);

        errs = err_cnt;
        check_all_counters(model_st);
        $display("model: %0d branches, %0d correct taken, %0d correct not taken, accuracy %0d%%",
                 model_st.prediction_count,
                 model_st.pred_taken_count - model_st.taken_incorrect_count,
                 model_st.pred_not_taken_count - model_st.not_taken_incorrect_count,
                 (model_st.correct_count * 32'd100) / model_st.prediction_count);
        finish_test("counters after stream", errs);

        errs = err_cnt;
        alias_a = 32'h0000_2010;
        alias_b = alias_a + (32'd1 << (MODEL_IDX_W + 2));  // same index, higher pc bits differ
        repeat (3) run_branch(alias_a, 1'b0);
        lookup_cycle(alias_b, 1'b0);          // shared entry saturated at strongly not taken
        repeat (3) run_branch(alias_a, 1'b1);
        lookup_cycle(alias_b, 1'b1);          // three taken steps reach strongly taken
        finish_test("aliased pcs", errs);

        errs = err_cnt;
        wb_write(wb_adr_t'(CTRL_REG), 32'h0000_0001);
        model_st = '0;                        // the table keeps its state
        check_all_counters(model_st);
        run_random_branches(NUM_AFTER_CLEAR);
        check_all_counters(model_st);
        finish_test("clear over the bus", errs);

        errs = err_cnt;
        wb_read(wb_adr_t'(CTRL_REG), data);
        check_stat("ctrl register", data, 32'd0);
        for (int a = 8; a < 16; a++) begin
            wb_read(wb_adr_t'(a), data);
            check_stat($sformatf("unmapped register %0d", a), data, 32'd0);
        end
        wb_write(wb_adr_t'(CORRECT_CNT_REG), 32'hffff_ffff);  // counters are read only
        check_all_counters(model_st);
        finish_test("register map and ack timing", errs);

        @(negedge CLK);
        $display("summary: %0d checks passed, %0d errors", pass_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+tb
logic/branch_pkg.sv
logic/bimodal_predictor.sv
logic/branch_tracker.sv
logic/stats_bus_fsm.sv
logic/branch_unit_top.sv
tb/branch_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the branch unit testbench with Verilator, runs it and checks the log.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=branch_unit_sim
LOG_FILE=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module branch_unit_tb \
    -f filelist.f \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "run_sim: verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "run_sim: simulation exited with status $sim_status"
    exit 1
fi

if grep -qF '*** PASSED ***' "$LOG_FILE"; then
    echo "run_sim: pass message found in $LOG_FILE"
    exit 0
fi
echo "run_sim: pass message not found in $LOG_FILE"
exit 1
